//--- hdl/feat_pkg.sv
`default_nettype none

package feat_pkg;

	localparam int WIN_LEN  = 3;                  // window side
	localparam int WIN_TAPS = WIN_LEN * WIN_LEN;  // taps per window
	localparam int STRIDE   = 2;                  // pooling and downsampling step

	// 2-bit code per tap, zero kept apart from the two signs
	typedef enum logic [1:0]
	{
		SIGN_ZERO = 2'b00,
		SIGN_POS  = 2'b01,
		SIGN_NEG  = 2'b10
	} sign_code_t;

endpackage

`default_nettype wire

//--- hdl/row_delay.sv
`timescale 1ns/1ps
`default_nettype none

module row_delay
#(
	parameter int DATA_W  = 27,
	parameter int ROW_LEN = 56
)(
	input  wire              i_sclk,
	input  wire              i_rst_n,
	input  wire              i_clear,
	input  wire              i_wr_en,
	input  wire [DATA_W-1:0] i_wr_data,
	input  wire              i_rd_en,
	output logic [DATA_W-1:0] o_rd_data
);

	localparam int PTR_W = (ROW_LEN > 1) ? $clog2(ROW_LEN) : 1;

	logic [DATA_W-1:0] mem [ROW_LEN];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;

	always_ff @(posedge i_sclk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (i_clear)
		begin
			wr_ptr <= '0;  // frame start rewinds both
			rd_ptr <= '0;
		end
		else
		begin
			if (i_wr_en)
				wr_ptr <= (wr_ptr == PTR_W'(ROW_LEN - 1)) ? '0 : wr_ptr + 1'b1;
			if (i_rd_en)
				rd_ptr <= (rd_ptr == PTR_W'(ROW_LEN - 1)) ? '0 : rd_ptr + 1'b1;
		end
	end

	// read sees the old word from one row back
	always_ff @(posedge i_sclk)
	begin
		if (i_wr_en)
			mem[wr_ptr] <= i_wr_data;
		if (i_rd_en)
			o_rd_data <= mem[rd_ptr];
	end

	// a row is written in one run of ROW_LEN words
	assert property (@(posedge i_sclk) disable iff (!i_rst_n)
		i_wr_en [*ROW_LEN] |=> !i_wr_en);

	// an end-of-frame flush reads one row and stops
	assert property (@(posedge i_sclk) disable iff (!i_rst_n)
		(i_rd_en && !i_wr_en) [*ROW_LEN] |=> !(i_rd_en && !i_wr_en));

endmodule

`default_nettype wire

//--- hdl/window_builder.sv
`timescale 1ns/1ps
`default_nettype none

module window_builder
	import feat_pkg::*;
#(
	parameter int DATA_W  = 27,
	parameter int ROW_LEN = 56,
	parameter int ROWS    = 56
)(
	input  wire                          i_sclk,
	input  wire                          i_rst_n,
	input  wire                          i_vsync,
	input  wire                          i_hsync,
	input  wire                          i_valid,
	input  wire  [DATA_W-1:0]            i_tdata,
	output logic                         o_win_valid,
	output logic                         o_win_row_start,
	output logic                         o_win_stride,
	output logic [WIN_TAPS*DATA_W-1:0]   o_win_tdata
);

	localparam int COL_W = (ROW_LEN > 1) ? $clog2(ROW_LEN) : 1;
	localparam int ROW_W = $clog2(ROWS + 1);

	logic [COL_W-1:0]  col;
	logic [ROW_W-1:0]  row;
	logic [1:0]        fl_dly;
	logic              fl_en;
	logic              pix_en;
	logic              last_pix;

	logic              b_wr;
	logic              b_rd;
	logic              b_emit;
	logic              b_top;
	logic              b_bot;
	logic              b_even;
	logic              b_first;
	logic              b_last;
	logic [DATA_W-1:0] b_pix;
	logic [DATA_W-1:0] d1_rd;
	logic [DATA_W-1:0] d2_rd;

	logic              c_emit;
	logic              c_top;
	logic              c_bot;
	logic              c_even;
	logic              c_first;
	logic              c_last;
	logic [DATA_W-1:0] c_pix;
	logic [DATA_W-1:0] c_mid;

	logic              tail;
	logic              shift_en;
	logic              win_valid;
	logic              win_even;
	logic [COL_W-1:0]  wcol;
	logic              left_edge;
	logic              right_edge;
	logic [DATA_W-1:0] col_in [WIN_LEN];
	logic [DATA_W-1:0] win_q  [WIN_LEN][WIN_LEN];  // [row][col], col 0 is left

	assign pix_en   = i_valid || fl_en;                 // real pixel or flush slot
	assign last_pix = pix_en && (col == COL_W'(ROW_LEN - 1));

	always_ff @(posedge i_sclk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			col    <= '0;
			row    <= '0;
			fl_dly <= '0;
			fl_en  <= 1'b0;
		end
		else if (i_vsync)
		begin
			col    <= '0;
			row    <= '0;
			fl_dly <= '0;
			fl_en  <= 1'b0;
		end
		else
		begin
			if (i_hsync)
				col <= '0;  // realign at every row start
			else if (pix_en)
				col <= last_pix ? '0 : col + 1'b1;
			if (i_valid && last_pix)
				row <= row + 1'b1;
			// wait for the last row to drain from the window shifter
			fl_dly <= {fl_dly[0], i_valid && last_pix && (row == ROW_W'(ROWS - 1))};
			if (fl_dly[1])
				fl_en <= 1'b1;
			else if (fl_en && last_pix)
				fl_en <= 1'b0;
		end
	end

	always_ff @(posedge i_sclk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			b_wr      <= 1'b0;
			b_rd      <= 1'b0;
			b_emit    <= 1'b0;
			c_emit    <= 1'b0;
			tail      <= 1'b0;
			win_valid <= 1'b0;
		end
		else
		begin
			b_wr      <= i_valid;
			b_rd      <= pix_en;
			b_emit    <= (i_valid && row != '0) || fl_en;  // row 0 only fills the delays
			c_emit    <= b_emit;
			tail      <= c_emit && c_last;                  // closes the right edge
			win_valid <= (c_emit && !c_first) || tail;
		end
	end

	always_ff @(posedge i_sclk)
	begin
		b_pix   <= i_tdata;
		b_top   <= (row == ROW_W'(1));  // centre is frame row 0
		b_bot   <= fl_en;               // centre is the last row
		b_even  <= ((row - 1'b1) % STRIDE) == 0;
		b_first <= (col == '0);
		b_last  <= (col == COL_W'(ROW_LEN - 1));
		c_pix   <= b_pix;
		c_mid   <= d1_rd;
		c_top   <= b_top;
		c_bot   <= b_bot;
		c_even  <= b_even;
		c_first <= b_first;
		c_last  <= b_last;
		if (c_emit)
			win_even <= c_even;
	end

	row_delay #(
		.DATA_W    (DATA_W),
		.ROW_LEN   (ROW_LEN)
	) row_delay_prev (
		.i_sclk    (i_sclk),
		.i_rst_n   (i_rst_n),
		.i_clear   (i_vsync),
		.i_wr_en   (i_valid),
		.i_wr_data (i_tdata),
		.i_rd_en   (pix_en),
		.o_rd_data (d1_rd)
	);

	row_delay #(
		.DATA_W    (DATA_W),
		.ROW_LEN   (ROW_LEN)
	) row_delay_prev2 (
		.i_sclk    (i_sclk),
		.i_rst_n   (i_rst_n),
		.i_clear   (i_vsync),
		.i_wr_en   (b_wr),
		.i_wr_data (d1_rd),
		.i_rd_en   (b_rd),
		.o_rd_data (d2_rd)
	);

	// vertical edge replication on the incoming column
	assign col_in[0]         = c_top ? c_mid : d2_rd;
	assign col_in[1]         = c_mid;
	assign col_in[WIN_LEN-1] = c_bot ? c_mid : c_pix;
	assign shift_en          = c_emit || tail;

	always_ff @(posedge i_sclk)
	begin
		if (shift_en)
		begin
			for (int r = 0; r < WIN_LEN; r++)
			begin
				for (int c = 0; c < WIN_LEN - 1; c++)
					win_q[r][c] <= win_q[r][c+1];
				win_q[r][WIN_LEN-1] <= col_in[r];
			end
		end
	end

	always_ff @(posedge i_sclk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			wcol <= '0;
		else if (i_vsync)
			wcol <= '0;
		else if (win_valid)
			wcol <= (wcol == COL_W'(ROW_LEN - 1)) ? '0 : wcol + 1'b1;
	end

	assign left_edge  = (wcol == '0);
	assign right_edge = (wcol == COL_W'(ROW_LEN - 1));

	// horizontal edge replication, taps row-major from the top row
	always_comb
	begin
		for (int r = 0; r < WIN_LEN; r++)
		begin
			o_win_tdata[(r*WIN_LEN)*DATA_W +: DATA_W] =
				left_edge ? win_q[r][1] : win_q[r][0];
			o_win_tdata[(r*WIN_LEN+1)*DATA_W +: DATA_W] = win_q[r][1];
			o_win_tdata[(r*WIN_LEN+WIN_LEN-1)*DATA_W +: DATA_W] =
				right_edge ? win_q[r][1] : win_q[r][WIN_LEN-1];
		end
	end

	assign o_win_valid     = win_valid;
	assign o_win_row_start = win_valid && left_edge;
	assign o_win_stride    = win_valid && win_even && ((wcol % STRIDE) == 0);

	// the source never streams more than one row after a row mark
	assert property (@(posedge i_sclk) disable iff (!i_rst_n)
		i_hsync ##1 i_valid [*ROW_LEN] |=> !i_valid);

endmodule

`default_nettype wire

//--- hdl/sign_window.sv
`timescale 1ns/1ps
`default_nettype none

module sign_window
	import feat_pkg::*;
#(
	parameter int DATA_W = 27
)(
	input  wire                         i_sclk,
	input  wire                         i_rst_n,
	input  wire                         i_win_valid,
	input  wire                         i_win_row_start,
	input  wire  [WIN_TAPS*DATA_W-1:0]  i_win_tdata,
	output logic                        o_hsync_c,
	output logic                        o_valid_c,
	output logic [2*WIN_TAPS-1:0]       o_tdata_c
);

	logic [2*WIN_TAPS-1:0] codes;

	function automatic sign_code_t sign_of(input logic [DATA_W-1:0] px);
		sign_code_t code;
		if (px == '0)
			code = SIGN_ZERO;
		else if (px[DATA_W-1])
			code = SIGN_NEG;  // msb set, negative
		else
			code = SIGN_POS;
		return code;
	endfunction

	always_comb
	begin
		for (int k = 0; k < WIN_TAPS; k++)
			codes[2*k +: 2] = sign_of(i_win_tdata[k*DATA_W +: DATA_W]);
	end

	always_ff @(posedge i_sclk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_valid_c <= 1'b0;
			o_hsync_c <= 1'b0;
		end
		else
		begin
			o_valid_c <= i_win_valid;
			o_hsync_c <= i_win_valid && i_win_row_start;
		end
	end

	always_ff @(posedge i_sclk)
	begin
		if (i_win_valid)
			o_tdata_c <= codes;
	end

endmodule

`default_nettype wire

//--- hdl/stride_pool.sv
`timescale 1ns/1ps
`default_nettype none

module stride_pool
	import feat_pkg::*;
#(
	parameter int DATA_W = 27
)(
	input  wire                         i_sclk,
	input  wire                         i_rst_n,
	input  wire                         i_win_valid,
	input  wire                         i_win_row_start,
	input  wire                         i_win_stride,
	input  wire  [WIN_TAPS*DATA_W-1:0]  i_win_tdata,
	output logic                        o_hsync_p,
	output logic                        o_valid_p,
	output logic [DATA_W-1:0]           o_tdata_m,
	output logic [DATA_W-1:0]           o_tdata_d
);

	localparam int CTR_TAP = WIN_TAPS / 2;  // centre of the window

	logic              take;
	logic [DATA_W-1:0] tap     [WIN_TAPS];
	logic [DATA_W-1:0] row_max [WIN_LEN];
	logic [DATA_W-1:0] s1_max  [WIN_LEN];
	logic [DATA_W-1:0] s1_ctr;
	logic [DATA_W-1:0] pool_max;
	logic              s1_valid;
	logic              s1_hsync;

	function automatic logic [DATA_W-1:0] smax(input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b);
		return ($signed(a) > $signed(b)) ? a : b;
	endfunction

	assign take = i_win_valid && i_win_stride;  // even row, even column only

	// first stage, maximum along each window row
	always_comb
	begin
		for (int k = 0; k < WIN_TAPS; k++)
			tap[k] = i_win_tdata[k*DATA_W +: DATA_W];
		for (int r = 0; r < WIN_LEN; r++)
		begin
			row_max[r] = tap[r*WIN_LEN];
			for (int c = 1; c < WIN_LEN; c++)
				row_max[r] = smax(row_max[r], tap[r*WIN_LEN+c]);
		end
	end

	// second stage across the row maxima
	always_comb
	begin
		pool_max = s1_max[0];
		for (int r = 1; r < WIN_LEN; r++)
			pool_max = smax(pool_max, s1_max[r]);
	end

	always_ff @(posedge i_sclk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			s1_valid  <= 1'b0;
			s1_hsync  <= 1'b0;
			o_valid_p <= 1'b0;
			o_hsync_p <= 1'b0;
		end
		else
		begin
			s1_valid  <= take;
			s1_hsync  <= take && i_win_row_start;
			o_valid_p <= s1_valid;
			o_hsync_p <= s1_hsync;
		end
	end

	always_ff @(posedge i_sclk)
	begin
		if (take)
		begin
			s1_max <= row_max;
			s1_ctr <= tap[CTR_TAP];  // rides along with the compare
		end
		if (s1_valid)
		begin
			o_tdata_m <= pool_max;
			o_tdata_d <= s1_ctr;
		end
	end

endmodule

`default_nettype wire

//--- hdl/feat_reshape_top.sv
`timescale 1ns/1ps
`default_nettype none

module feat_reshape_top
	import feat_pkg::*;
#(
	parameter int DATA_W  = 27,
	parameter int ROW_LEN = 56,
	parameter int ROWS    = 56
)(
	input  wire                      i_sclk,
	input  wire                      i_rst_n,
	input  wire                      i_vsync,
	input  wire                      i_hsync,
	input  wire                      i_valid,
	input  wire  [DATA_W-1:0]        i_tdata,

	output wire                      o_hsync_c,
	output wire                      o_valid_c,
	output wire  [2*WIN_TAPS-1:0]    o_tdata_c,

	output wire                      o_hsync_p,
	output wire                      o_valid_p,
	output wire  [DATA_W-1:0]        o_tdata_m,
	output wire  [DATA_W-1:0]        o_tdata_d
);

	wire                         win_valid;
	wire                         win_row_start;
	wire                         win_stride;  // even centre row and column
	wire [WIN_TAPS*DATA_W-1:0]   win_tdata;

	window_builder #(
		.DATA_W          (DATA_W),
		.ROW_LEN         (ROW_LEN),
		.ROWS            (ROWS)
	) window_builder_inst (
		.i_sclk          (i_sclk),
		.i_rst_n         (i_rst_n),
		.i_vsync         (i_vsync),
		.i_hsync         (i_hsync),
		.i_valid         (i_valid),
		.i_tdata         (i_tdata),
		.o_win_valid     (win_valid),
		.o_win_row_start (win_row_start),
		.o_win_stride    (win_stride),
		.o_win_tdata     (win_tdata)
	);

	// full-rate sign codes
	sign_window #(
		.DATA_W          (DATA_W)
	) sign_window_inst (
		.i_sclk          (i_sclk),
		.i_rst_n         (i_rst_n),
		.i_win_valid     (win_valid),
		.i_win_row_start (win_row_start),
		.i_win_tdata     (win_tdata),
		.o_hsync_c       (o_hsync_c),
		.o_valid_c       (o_valid_c),
		.o_tdata_c       (o_tdata_c)
	);

	// max pooling and centre downsample share the stride windows
	stride_pool #(
		.DATA_W          (DATA_W)
	) stride_pool_inst (
		.i_sclk          (i_sclk),
		.i_rst_n         (i_rst_n),
		.i_win_valid     (win_valid),
		.i_win_row_start (win_row_start),
		.i_win_stride    (win_stride),
		.i_win_tdata     (win_tdata),
		.o_hsync_p       (o_hsync_p),
		.o_valid_p       (o_valid_p),
		.o_tdata_m       (o_tdata_m),
		.o_tdata_d       (o_tdata_d)
	);

endmodule

`default_nettype wire

//--- include/feat_ref_model.svh
`ifndef FEAT_REF_MODEL_SVH
`define FEAT_REF_MODEL_SVH

// pulls a frame coordinate back inside 0..hi
function automatic int clamp_idx(input int v, input int hi);
	int res;
	res = v;
	if (res < 0)
		res = 0;
	else if (res > hi)
		res = hi;
	return res;
endfunction

// tap k of the window centred on (r, c), row-major from the top row
function automatic logic [DATA_W-1:0] window_tap(input int r, input int c, input int k);
	int pr;
	int pc;
	pr = clamp_idx(r + k / 3 - 1, ROWS - 1);     // nearest row inside the frame
	pc = clamp_idx(c + k % 3 - 1, ROW_LEN - 1);  // nearest column inside the frame
	return frame_px[pr][pc];
endfunction

function automatic logic [1:0] code_of(input logic [DATA_W-1:0] px);
	logic [1:0] code;
	if (px == '0)
		code = SIGN_ZERO;
	else if ($signed(px) < 0)
		code = SIGN_NEG;
	else
		code = SIGN_POS;
	return code;
endfunction

// queues the expected outputs of the frame now held in frame_px
task automatic expect_frame();
	logic [2*WIN_TAPS-1:0] codes;
	logic [DATA_W-1:0]     tap;
	logic [DATA_W-1:0]     best;
	for (int r = 0; r < ROWS; r++)
	begin
		for (int c = 0; c < ROW_LEN; c++)
		begin
			best = window_tap(r, c, 0);
			for (int k = 0; k < 9; k++)
			begin
				tap = window_tap(r, c, k);
				codes[2*k +: 2] = code_of(tap);
				if ($signed(tap) > $signed(best))
					best = tap;
			end
			exp_code_q.push_back(codes);
			exp_hs_c_q.push_back(c == 0);
			if ((r % 2 == 0) && (c % 2 == 0))  // stride-2 grid
			begin
				exp_max_q.push_back(best);
				exp_ctr_q.push_back(window_tap(r, c, 4));
				exp_hs_p_q.push_back(c == 0);
			end
		end
	end
endtask

task automatic check_value(input string name, input logic [31:0] got,
	input logic [31:0] exp);
	if (got !== exp)
	begin
		value_errors++;
		$display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
	end
endtask

`endif

//--- sim/tb_feat_reshape.sv
`timescale 1ns/1ps
`default_nettype none

module tb_feat_reshape
	import feat_pkg::*;
();

	localparam int          DATA_W  = 16;
	localparam int          ROW_LEN = 12;
	localparam int          ROWS    = 8;
	localparam int          FRAMES  = 3;
	localparam logic [31:0] SEED    = 32'hd195_df22;
	localparam int          WATCHDOG_CYCLES =
		FRAMES * (ROWS * (ROW_LEN + 10) + ROW_LEN + 20) + 200;

	logic                  i_sclk;
	logic                  i_rst_n;
	logic                  i_vsync;
	logic                  i_hsync;
	logic                  i_valid;
	logic [DATA_W-1:0]     i_tdata;
	wire                   o_hsync_c;
	wire                   o_valid_c;
	wire  [2*WIN_TAPS-1:0] o_tdata_c;
	wire                   o_hsync_p;
	wire                   o_valid_p;
	wire  [DATA_W-1:0]     o_tdata_m;
	wire  [DATA_W-1:0]     o_tdata_d;

	logic [DATA_W-1:0]     frame_px [ROWS][ROW_LEN];
	logic [2*WIN_TAPS-1:0] exp_code_q [$];
	bit                    exp_hs_c_q [$];
	logic [DATA_W-1:0]     exp_max_q  [$];
	logic [DATA_W-1:0]     exp_ctr_q  [$];
	bit                    exp_hs_p_q [$];
	int                    value_errors;
	int                    flow_errors;
	int                    seen_c;
	int                    seen_p;

	`include "feat_ref_model.svh"

	feat_reshape_top #(
		.DATA_W    (DATA_W),
		.ROW_LEN   (ROW_LEN),
		.ROWS      (ROWS)
	) feat_reshape_top_inst (
		.i_sclk    (i_sclk),
		.i_rst_n   (i_rst_n),
		.i_vsync   (i_vsync),
		.i_hsync   (i_hsync),
		.i_valid   (i_valid),
		.i_tdata   (i_tdata),
		.o_hsync_c (o_hsync_c),
		.o_valid_c (o_valid_c),
		.o_tdata_c (o_tdata_c),
		.o_hsync_p (o_hsync_p),
		.o_valid_p (o_valid_p),
		.o_tdata_m (o_tdata_m),
		.o_tdata_d (o_tdata_d)
	);

	always #2 i_sclk = ~i_sclk;

	task automatic next_cycle();
		@(posedge i_sclk);
		#1;  // inputs settle well after the edge
	endtask

	task automatic drive_idle(input int n);
		for (int i = 0; i < n; i++)
		begin
			next_cycle();
			i_vsync = 1'b0;
			i_hsync = 1'b0;
			i_valid = 1'b0;
		end
	endtask

	function automatic logic [DATA_W-1:0] random_pixel();
		logic [DATA_W-1:0] px;
		px = DATA_W'($urandom);
		if ($urandom % 8 == 0)
			px = '0;  // keep zero codes frequent
		return px;
	endfunction

	task automatic send_frame();
		int gap;
		for (int r = 0; r < ROWS; r++)
		begin
			for (int c = 0; c < ROW_LEN; c++)
				frame_px[r][c] = random_pixel();
		end
		expect_frame();
		for (int r = 0; r < ROWS; r++)
		begin
			gap = 4 + $urandom % 7;
			drive_idle(gap - 1);
			next_cycle();
			i_vsync = (r == 0);  // frame mark rides with the first row mark
			i_hsync = 1'b1;
			i_valid = 1'b0;
			for (int c = 0; c < ROW_LEN; c++)
			begin
				next_cycle();
				i_vsync = 1'b0;
				i_hsync = 1'b0;
				i_valid = 1'b1;
				i_tdata = frame_px[r][c];
			end
		end
		drive_idle(ROW_LEN + 12);  // room for the end-of-frame flush
	endtask

	task automatic report_missing();
		if (exp_code_q.size() != 0)
		begin
			flow_errors++;
			$display("%0d sign windows never came out", exp_code_q.size());
		end
		if (exp_max_q.size() != 0)
		begin
			flow_errors++;
			$display("%0d pooled outputs never came out", exp_max_q.size());
		end
		if (seen_c != FRAMES * ROWS * ROW_LEN
			|| seen_p != FRAMES * (ROWS / 2) * (ROW_LEN / 2))
		begin
			flow_errors++;
			$display("output counts are wrong: %0d sign windows, %0d pooled outputs",
				seen_c, seen_p);
		end
	endtask

	task automatic print_summary();
		$display("errors: value %0d, flow %0d", value_errors, flow_errors);
	endtask

	always @(negedge i_sclk)
	begin
		if (!i_rst_n)
		begin
			check_value("o_valid_c", o_valid_c, 1'b0);
			check_value("o_hsync_c", o_hsync_c, 1'b0);
			check_value("o_valid_p", o_valid_p, 1'b0);
			check_value("o_hsync_p", o_hsync_p, 1'b0);
		end
		else
		begin
			if (o_valid_c)
			begin
				seen_c++;
				if (exp_code_q.size() == 0)
				begin
					flow_errors++;
					$display("sign output came with no window expected at %0t", $time);
				end
				else
				begin
					check_value("o_tdata_c", o_tdata_c, exp_code_q.pop_front());
					check_value("o_hsync_c", o_hsync_c, exp_hs_c_q.pop_front());
				end
			end
			else
				check_value("o_hsync_c", o_hsync_c, 1'b0);
			if (o_valid_p)
			begin
				seen_p++;
				if (exp_max_q.size() == 0)
				begin
					flow_errors++;
					$display("pooled output came with nothing expected at %0t", $time);
				end
				else
				begin
					check_value("o_tdata_m", o_tdata_m, exp_max_q.pop_front());
					check_value("o_tdata_d", o_tdata_d, exp_ctr_q.pop_front());
					check_value("o_hsync_p", o_hsync_p, exp_hs_p_q.pop_front());
				end
			end
			else
				check_value("o_hsync_p", o_hsync_p, 1'b0);
		end
	end

	initial
	begin
		int drain;
		i_sclk       = 1'b0;
		i_rst_n      = 1'b0;
		i_vsync      = 1'b0;
		i_hsync      = 1'b0;
		i_valid      = 1'b0;
		i_tdata      = '0;
		value_errors = 0;
		flow_errors  = 0;
		seen_c       = 0;
		seen_p       = 0;
		void'($urandom(SEED));
		repeat (16) @(posedge i_sclk);
		#1;
		i_rst_n = 1'b1;
		drive_idle(8);  // any output here meets empty queues
		for (int f = 0; f < FRAMES; f++)
			send_frame();
		drain = 0;
		while ((exp_code_q.size() != 0 || exp_max_q.size() != 0) && drain < 64)
		begin
			@(negedge i_sclk);
			drain++;
		end
		repeat (8) @(negedge i_sclk);  // catch trailing extras
		report_missing();
		print_summary();
		if (value_errors == 0 && flow_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge i_sclk);
		$display("watchdog expired after %0d cycles, the run stalled", WATCHDOG_CYCLES);
		report_missing();
		print_summary();
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- feat_reshape.f
+incdir+include
hdl/feat_pkg.sv
hdl/row_delay.sv
hdl/window_builder.sv
hdl/sign_window.sv
hdl/stride_pool.sv
hdl/feat_reshape_top.sv
sim/tb_feat_reshape.sv
